// File: addr_decoder.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module addr_decoder (
    input  logic                 data_req_i,
    input  mem_pkg::bus_addr_t   data_addr_i,
    input  logic                 data_we_i,
    input  mem_pkg::byte_en_t    data_be_i,
    input  mem_pkg::word_t       data_wdata_i,
    output mem_pkg::data_req_t   ram_req_o,
    output mem_pkg::periph_req_t periph_req_o,
    output mem_pkg::mem_target_e target_o
);
    import mem_pkg::*;

    logic in_ram;
    logic is_status;
    logic is_exit;
    logic is_exit_zero;
    logic is_timer_mask;
    logic is_timer_cnt;
    logic is_periph;

    assign in_ram        = (data_addr_i[31:`MEM_ADDR_WIDTH] == '0);
    assign is_status     = (data_addr_i == `MEM_STATUS_ADDR);
    assign is_exit       = (data_addr_i == `MEM_EXIT_ADDR);
    assign is_exit_zero  = (data_addr_i == `MEM_EXIT_ZERO_ADDR);
    assign is_timer_mask = (data_addr_i == `MEM_TIMER_MASK_ADDR);
    assign is_timer_cnt  = (data_addr_i == `MEM_TIMER_CNT_ADDR);
    assign is_periph     = is_status | is_exit | is_exit_zero | is_timer_mask | is_timer_cnt;

    always_comb begin
        ram_req_o          = '0;
        periph_req_o       = '0;
        target_o           = TGT_ERR;
        ram_req_o.we       = data_we_i;
        ram_req_o.be       = data_be_i;
        ram_req_o.addr     = data_addr_i[`MEM_ADDR_WIDTH-1:0];
        ram_req_o.wdata    = data_wdata_i;
        periph_req_o.wdata = data_wdata_i;

        if (data_req_i) begin
            if (in_ram) begin
                ram_req_o.valid = 1'b1;
                target_o        = TGT_RAM;
            end else if (is_periph) begin
                // Reads of a peripheral only get a zero response.
                target_o = TGT_PER;
                if (data_we_i) begin
                    periph_req_o.status_we     = is_status;
                    periph_req_o.exit_we       = is_exit;
                    periph_req_o.exit_zero_we  = is_exit_zero;
                    periph_req_o.timer_mask_we = is_timer_mask;
                    periph_req_o.timer_cnt_we  = is_timer_cnt;
                end
            end
        end
    end

    // The peripheral addresses must not overlap.
    always_comb begin
        assert ($onehot0({periph_req_o.status_we, periph_req_o.exit_we,
                          periph_req_o.exit_zero_we, periph_req_o.timer_mask_we,
                          periph_req_o.timer_cnt_we}))
            else $error("addr_decoder: more than one peripheral strobe set");
    end

endmodule

// File: dual_port_ram.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module dual_port_ram #(
    parameter int ADDR_WIDTH = `MEM_ADDR_WIDTH
) (
    input  logic                         clk_i,

    input  logic                         instr_en_i,
    input  logic [ADDR_WIDTH-1:0]        instr_addr_i,
    output logic [`MEM_DATA_WIDTH-1:0]   instr_rdata_o,

    input  logic                         data_en_i,
    input  logic                         data_we_i,
    input  logic [`MEM_DATA_WIDTH/8-1:0] data_be_i,
    input  logic [ADDR_WIDTH-1:0]        data_addr_i,
    input  logic [`MEM_DATA_WIDTH-1:0]   data_wdata_i,
    output logic [`MEM_DATA_WIDTH-1:0]   data_rdata_o
);
    localparam int NUM_BYTES = `MEM_DATA_WIDTH / 8;

    logic [7:0]            mem [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] instr_base;
    logic [ADDR_WIDTH-1:0] data_base;

    // Both ports access whole aligned words.
    assign instr_base = instr_addr_i & ~ADDR_WIDTH'(NUM_BYTES - 1);
    assign data_base  = data_addr_i & ~ADDR_WIDTH'(NUM_BYTES - 1);

    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_base + ADDR_WIDTH'(i)];
            end
        end
    end

    // A write loads zero into the read register, so writes answer with zero data.
    always_ff @(posedge clk_i) begin
        if (data_en_i) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (data_we_i) begin
                    if (data_be_i[i]) begin
                        mem[data_base + ADDR_WIDTH'(i)] <= data_wdata_i[8*i +: 8];
                    end
                    data_rdata_o[8*i +: 8] <= 8'h00;
                end else begin
                    data_rdata_o[8*i +: 8] <= mem[data_base + ADDR_WIDTH'(i)];
                end
            end
        end
    end

endmodule

// File: mem_checker.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_checker (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  int                   test_id_i,
    input  logic                 data_req_i,
    input  logic                 data_gnt_i,
    input  mem_pkg::bus_addr_t   data_addr_i,
    input  logic                 data_we_i,
    input  mem_pkg::byte_en_t    data_be_i,
    input  mem_pkg::word_t       data_wdata_i,
    input  logic                 data_rvalid_i,
    input  mem_pkg::word_t       data_rdata_i,
    input  logic                 instr_req_i,
    input  logic                 instr_gnt_i,
    input  mem_pkg::ram_addr_t   instr_addr_i,
    input  logic                 instr_rvalid_i,
    input  mem_pkg::word_t       instr_rdata_i,
    input  logic                 irq_ack_i,
    input  mem_pkg::irq_id_t     irq_id_i,
    input  logic                 irq_timer_i,
    input  logic                 tests_passed_i,
    input  logic                 tests_failed_i,
    input  logic                 exit_valid_i,
    input  mem_pkg::word_t       exit_value_i,
    output int                   errors_o,
    output int                   pending_o
);
    import mem_pkg::*;

    localparam int NUM_WORDS = 2 ** (`MEM_ADDR_WIDTH - 2);

    word_t ref_mem [NUM_WORDS];
    word_t data_exp_q [$];
    word_t instr_exp_q [$];
    word_t exp_word;
    word_t exp_exit_value;
    word_t ref_mask;
    word_t ref_cnt;
    logic  exp_passed;
    logic  exp_failed;
    logic  exp_exit_valid;
    logic  exp_irq;
    logic  accept;
    logic  wr;
    logic  [`MEM_ADDR_WIDTH-3:0] idx;

    // Merges the enabled bytes of a write into the old word.
    function automatic word_t write_bytes(input word_t old_word, input word_t wdata,
                                          input byte_en_t be);
        word_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "ram_read_write";
            2:       return "instr_fetch";
            3:       return "zero_reads";
            4:       return "status_exit";
            5:       return "timer_irq";
            default: return "reset";
        endcase
    endfunction

    task automatic compare(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors_o++;
            $display("CHECK FAILED: %s %s expected %h actual %h",
                     test_name(test_id_i), what, expected, actual);
        end
    endtask

    // The model grants every request in its own cycle.
    assign accept = data_req_i;
    assign wr     = accept & data_we_i;

    // Outputs sampled here were set at the previous edge.
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            data_exp_q.delete();
            instr_exp_q.delete();
            errors_o       = 0;
            exp_passed     = 1'b0;
            exp_failed     = 1'b0;
            exp_exit_valid = 1'b0;
            exp_exit_value = '0;
            ref_mask       = '0;
            ref_cnt        = '0;
            exp_irq        = 1'b0;
        end else begin
            if (data_rvalid_i && data_exp_q.size() == 0) begin
                errors_o++;
                $display("%s: data rvalid arrived with no request outstanding",
                         test_name(test_id_i));
            end else if (data_rvalid_i) begin
                exp_word = data_exp_q.pop_front();
                compare("data_rdata", exp_word, data_rdata_i);
            end
            if (instr_rvalid_i && instr_exp_q.size() == 0) begin
                errors_o++;
                $display("%s: instruction rvalid arrived with no fetch outstanding",
                         test_name(test_id_i));
            end else if (instr_rvalid_i) begin
                exp_word = instr_exp_q.pop_front();
                compare("instr_rdata", exp_word, instr_rdata_i);
            end
            if (data_exp_q.size() != 0 || instr_exp_q.size() != 0) begin
                errors_o++;
                $display("%s: a request got no rvalid in the following cycle",
                         test_name(test_id_i));
                data_exp_q.delete();
                instr_exp_q.delete();
            end
            compare("data_gnt", word_t'(data_req_i), word_t'(data_gnt_i));
            compare("instr_gnt", word_t'(instr_req_i), word_t'(instr_gnt_i));
            compare("tests_passed", word_t'(exp_passed), word_t'(tests_passed_i));
            compare("tests_failed", word_t'(exp_failed), word_t'(tests_failed_i));
            compare("exit_valid", word_t'(exp_exit_valid), word_t'(exit_valid_i));
            compare("exit_value", exp_exit_value, exit_value_i);
            compare("irq_timer", word_t'(exp_irq), word_t'(irq_timer_i));

            // Fetches see the RAM before a write at the same edge.
            if (instr_req_i) begin
                instr_exp_q.push_back(ref_mem[instr_addr_i[`MEM_ADDR_WIDTH-1:2]]);
            end
            if (accept && data_addr_i[31:`MEM_ADDR_WIDTH] == '0) begin
                idx = data_addr_i[`MEM_ADDR_WIDTH-1:2];
                if (data_we_i) begin
                    ref_mem[idx] = write_bytes(ref_mem[idx], data_wdata_i, data_be_i);
                    data_exp_q.push_back('0);
                end else begin
                    data_exp_q.push_back(ref_mem[idx]);
                end
            end else if (accept) begin
                data_exp_q.push_back('0);
            end

            exp_passed = wr && data_addr_i == `MEM_STATUS_ADDR
                         && data_wdata_i == `MEM_PASS_MAGIC;
            exp_failed = wr && data_addr_i == `MEM_STATUS_ADDR
                         && data_wdata_i == `MEM_FAIL_VALUE;
            exp_exit_valid = wr && (data_addr_i == `MEM_EXIT_ADDR
                                    || data_addr_i == `MEM_EXIT_ZERO_ADDR);
            if (wr && data_addr_i == `MEM_EXIT_ADDR) begin
                exp_exit_value = data_wdata_i;
            end else if (wr && data_addr_i == `MEM_EXIT_ZERO_ADDR) begin
                exp_exit_value = '0;
            end

            // A register write holds the countdown for one cycle.
            if (wr && data_addr_i == `MEM_TIMER_MASK_ADDR) begin
                ref_mask = data_wdata_i;
            end else if (wr && data_addr_i == `MEM_TIMER_CNT_ADDR) begin
                ref_cnt = data_wdata_i;
            end else if (ref_cnt != '0) begin
                if (ref_cnt == 32'd1 && ref_mask[`MEM_TIMER_IRQ_ID]) begin
                    exp_irq = 1'b1;
                end
                ref_cnt = ref_cnt - 32'd1;
            end
            if (irq_ack_i && irq_id_i == 5'(`MEM_TIMER_IRQ_ID)) begin
                exp_irq = 1'b0;
            end
            pending_o = data_exp_q.size() + instr_exp_q.size();
        end
    end

endmodule

// File: mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Byte-address width of the RAM and width of a data word.
`define MEM_ADDR_WIDTH 16
`define MEM_DATA_WIDTH 32

// Test status and exit registers.
`define MEM_STATUS_ADDR    32'h2000_0000
`define MEM_EXIT_ADDR      32'h2000_0004
`define MEM_EXIT_ZERO_ADDR 32'h2000_0010

// Timer registers.
`define MEM_TIMER_MASK_ADDR 32'h1500_0000
`define MEM_TIMER_CNT_ADDR  32'h1500_0004

`define MEM_PASS_MAGIC   32'd123456789
`define MEM_FAIL_VALUE   32'd1
`define MEM_TIMER_IRQ_ID 7

`endif

// File: mem_model_top.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_model_top (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               instr_req_i,
    input  mem_pkg::ram_addr_t instr_addr_i,
    output mem_pkg::word_t     instr_rdata_o,
    output logic               instr_rvalid_o,
    output logic               instr_gnt_o,

    input  logic               data_req_i,
    input  mem_pkg::bus_addr_t data_addr_i,
    input  logic               data_we_i,
    input  mem_pkg::byte_en_t  data_be_i,
    input  mem_pkg::word_t     data_wdata_i,
    output mem_pkg::word_t     data_rdata_o,
    output logic               data_rvalid_o,
    output logic               data_gnt_o,

    input  mem_pkg::irq_id_t   irq_id_i,
    input  logic               irq_ack_i,
    output logic               irq_timer_o,

    output logic               tests_passed_o,
    output logic               tests_failed_o,
    output logic               exit_valid_o,
    output mem_pkg::word_t     exit_value_o
);
    import mem_pkg::*;

    data_req_t   ram_req;
    periph_req_t periph_req;
    mem_target_e target;
    word_t       ram_data_rdata;
    logic        data_accept;

    // Both ports always grant in the request cycle.
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;
    assign data_accept = data_req_i & data_gnt_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    addr_decoder addr_decoder_i (
        .data_req_i   ( data_req_i   ),
        .data_addr_i  ( data_addr_i  ),
        .data_we_i    ( data_we_i    ),
        .data_be_i    ( data_be_i    ),
        .data_wdata_i ( data_wdata_i ),
        .ram_req_o    ( ram_req      ),
        .periph_req_o ( periph_req   ),
        .target_o     ( target       )
    );

    dual_port_ram #(
        .ADDR_WIDTH ( `MEM_ADDR_WIDTH )
    ) dual_port_ram_i (
        .clk_i         ( clk_i          ),
        .instr_en_i    ( instr_req_i    ),
        .instr_addr_i  ( instr_addr_i   ),
        .instr_rdata_o ( instr_rdata_o  ),
        .data_en_i     ( ram_req.valid  ),
        .data_we_i     ( ram_req.we     ),
        .data_be_i     ( ram_req.be     ),
        .data_addr_i   ( ram_req.addr   ),
        .data_wdata_i  ( ram_req.wdata  ),
        .data_rdata_o  ( ram_data_rdata )
    );

    periph_regs periph_regs_i (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .periph_req_i   ( periph_req     ),
        .irq_ack_i      ( irq_ack_i      ),
        .irq_id_i       ( irq_id_i       ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   ),
        .irq_timer_o    ( irq_timer_o    )
    );

    response_stage response_stage_i (
        .clk_i         ( clk_i          ),
        .rst_ni        ( rst_ni         ),
        .accept_i      ( data_accept    ),
        .target_i      ( target         ),
        .ram_rdata_i   ( ram_data_rdata ),
        .data_rvalid_o ( data_rvalid_o  ),
        .data_rdata_o  ( data_rdata_o   )
    );

endmodule

// File: mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    typedef logic [`MEM_DATA_WIDTH-1:0]   word_t;
    typedef logic [31:0]                  bus_addr_t;
    typedef logic [`MEM_ADDR_WIDTH-1:0]   ram_addr_t;
    typedef logic [`MEM_DATA_WIDTH/8-1:0] byte_en_t;
    typedef logic [4:0]                   irq_id_t;

    // Where a data request goes.
    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_PER,
        TGT_ERR
    } mem_target_e;

    typedef struct packed {
        logic      valid;
        logic      we;
        byte_en_t  be;
        ram_addr_t addr;
        word_t     wdata;
    } data_req_t;

    // One write strobe per peripheral register.
    typedef struct packed {
        logic  status_we;
        logic  exit_we;
        logic  exit_zero_we;
        logic  timer_mask_we;
        logic  timer_cnt_we;
        word_t wdata;
    } periph_req_t;

endpackage

// File: periph_regs.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module periph_regs (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  mem_pkg::periph_req_t periph_req_i,
    input  logic                 irq_ack_i,
    input  mem_pkg::irq_id_t     irq_id_i,
    output logic                 tests_passed_o,
    output logic                 tests_failed_o,
    output logic                 exit_valid_o,
    output mem_pkg::word_t       exit_value_o,
    output logic                 irq_timer_o
);
    import mem_pkg::*;

    word_t timer_mask_q;
    word_t timer_cnt_q;
    logic  timer_write;
    logic  timer_ack;

    assign timer_write = periph_req_i.timer_mask_we | periph_req_i.timer_cnt_we;
    assign timer_ack   = irq_ack_i && (irq_id_i == irq_id_t'(`MEM_TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else begin
            tests_passed_o <= periph_req_i.status_we && (periph_req_i.wdata == `MEM_PASS_MAGIC);
            tests_failed_o <= periph_req_i.status_we && (periph_req_i.wdata == `MEM_FAIL_VALUE);
            exit_valid_o   <= periph_req_i.exit_we | periph_req_i.exit_zero_we;
            if (periph_req_i.exit_we) begin
                exit_value_o <= periph_req_i.wdata;
            end else if (periph_req_i.exit_zero_we) begin
                exit_value_o <= '0;
            end
        end
    end

    // The countdown pauses in a cycle with a timer register write.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= '0;
            timer_cnt_q  <= '0;
            irq_timer_o  <= 1'b0;
        end else begin
            if (periph_req_i.timer_mask_we) begin
                timer_mask_q <= periph_req_i.wdata;
            end else if (periph_req_i.timer_cnt_we) begin
                timer_cnt_q <= periph_req_i.wdata;
            end else if (timer_cnt_q != '0) begin
                timer_cnt_q <= timer_cnt_q - 1'b1;
                if (timer_cnt_q == word_t'(1) && timer_mask_q[`MEM_TIMER_IRQ_ID]) begin
                    irq_timer_o <= 1'b1;
                end
            end
            if (timer_ack) begin
                irq_timer_o <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        timer_write |=> timer_cnt_q ==
            $past(periph_req_i.timer_cnt_we ? periph_req_i.wdata : timer_cnt_q))
        else $error("periph_regs: timer counted down during a register write");

endmodule

// File: response_stage.sv
`timescale 1ns/1ps

module response_stage (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 accept_i,
    input  mem_pkg::mem_target_e target_i,
    input  mem_pkg::word_t       ram_rdata_i,
    output logic                 data_rvalid_o,
    output mem_pkg::word_t       data_rdata_o
);
    import mem_pkg::*;

    mem_target_e target_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_rvalid_o <= 1'b0;
            target_q      <= TGT_ERR;
        end else begin
            data_rvalid_o <= accept_i;
            if (accept_i) begin
                target_q <= target_i;
            end
        end
    end

    // Only the RAM returns data; peripherals and bad addresses read as zero.
    assign data_rdata_o = (data_rvalid_o && target_q == TGT_RAM) ? ram_rdata_i : '0;

    // Every accepted request gets exactly one response, in the next cycle.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_o == $past(accept_i))
        else $error("response_stage: rvalid does not follow accept by one cycle");

endmodule

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_mem_model -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// File: tb_mem_model.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_model;
    import mem_pkg::*;

    localparam int NUM_ADDRS   = 16;
    localparam int SEL_PASSED  = 0;
    localparam int SEL_FAILED  = 1;
    localparam int SEL_EXIT    = 2;
    localparam int SEL_IRQ     = 3;
    localparam int TIMER_COUNT = 6;

    logic      clk;
    logic      rst_n;
    logic      instr_req;
    ram_addr_t instr_addr;
    word_t     instr_rdata;
    logic      instr_rvalid;
    logic      instr_gnt;
    logic      data_req;
    bus_addr_t data_addr;
    logic      data_we;
    byte_en_t  data_be;
    word_t     data_wdata;
    word_t     data_rdata;
    logic      data_rvalid;
    logic      data_gnt;
    irq_id_t   irq_id;
    logic      irq_ack;
    logic      irq_timer;
    logic      tests_passed;
    logic      tests_failed;
    logic      exit_valid;
    word_t     exit_value;
    int        test_id;
    int        check_errors;
    int        pending;
    int        timeouts;
    integer    seed;
    ram_addr_t addrs [NUM_ADDRS];

    mem_model_top dut0 (
        .clk_i          ( clk          ),
        .rst_ni         ( rst_n        ),
        .instr_req_i    ( instr_req    ),
        .instr_addr_i   ( instr_addr   ),
        .instr_rdata_o  ( instr_rdata  ),
        .instr_rvalid_o ( instr_rvalid ),
        .instr_gnt_o    ( instr_gnt    ),
        .data_req_i     ( data_req     ),
        .data_addr_i    ( data_addr    ),
        .data_we_i      ( data_we      ),
        .data_be_i      ( data_be      ),
        .data_wdata_i   ( data_wdata   ),
        .data_rdata_o   ( data_rdata   ),
        .data_rvalid_o  ( data_rvalid  ),
        .data_gnt_o     ( data_gnt     ),
        .irq_id_i       ( irq_id       ),
        .irq_ack_i      ( irq_ack      ),
        .irq_timer_o    ( irq_timer    ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   )
    );

    mem_checker mem_checker0 (
        .clk_i          ( clk          ),
        .rst_ni         ( rst_n        ),
        .test_id_i      ( test_id      ),
        .data_req_i     ( data_req     ),
        .data_gnt_i     ( data_gnt     ),
        .data_addr_i    ( data_addr    ),
        .data_we_i      ( data_we      ),
        .data_be_i      ( data_be      ),
        .data_wdata_i   ( data_wdata   ),
        .data_rvalid_i  ( data_rvalid  ),
        .data_rdata_i   ( data_rdata   ),
        .instr_req_i    ( instr_req    ),
        .instr_gnt_i    ( instr_gnt    ),
        .instr_addr_i   ( instr_addr   ),
        .instr_rvalid_i ( instr_rvalid ),
        .instr_rdata_i  ( instr_rdata  ),
        .irq_ack_i      ( irq_ack      ),
        .irq_id_i       ( irq_id       ),
        .irq_timer_i    ( irq_timer    ),
        .tests_passed_i ( tests_passed ),
        .tests_failed_i ( tests_failed ),
        .exit_valid_i   ( exit_valid   ),
        .exit_value_i   ( exit_value   ),
        .errors_o       ( check_errors ),
        .pending_o      ( pending      )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic data_access(input logic we, input bus_addr_t addr, input byte_en_t be,
                               input word_t wdata);
        @(negedge clk);
        data_req   = 1'b1;
        data_we    = we;
        data_addr  = addr;
        data_be    = be;
        data_wdata = wdata;
    endtask

    task automatic instr_fetch(input ram_addr_t addr);
        @(negedge clk);
        instr_req  = 1'b1;
        instr_addr = addr;
    endtask

    task automatic bus_idle();
        @(negedge clk);
        data_req  = 1'b0;
        data_we   = 1'b0;
        instr_req = 1'b0;
        irq_ack   = 1'b0;
    endtask

    function automatic logic watched_level(input int sel);
        case (sel)
            SEL_PASSED: return tests_passed;
            SEL_FAILED: return tests_failed;
            SEL_EXIT:   return exit_valid;
            default:    return irq_timer;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input int limit,
                              input string what);
        int cycles;
        cycles = 0;
        while (watched_level(sel) !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (watched_level(sel) !== level) begin
            timeouts++;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (pending != 0) begin
            timeouts++;
            $display("Timeout: %s responses never arrived", what);
        end
    endtask

    initial begin
        int pick;
        seed       = 32'hef0c2345;
        rst_n      = 1'b0;
        instr_req  = 1'b0;
        instr_addr = '0;
        data_req   = 1'b0;
        data_addr  = '0;
        data_we    = 1'b0;
        data_be    = '0;
        data_wdata = '0;
        irq_id     = '0;
        irq_ack    = 1'b0;
        test_id    = 0;
        timeouts   = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Full words first, so that later partial writes never leave unknown bytes.
        test_id = 1;
        for (int i = 0; i < NUM_ADDRS; i++) begin
            addrs[i] = ram_addr_t'($random(seed)) & 16'hfffc;
            data_access(1'b1, bus_addr_t'(addrs[i]), 4'hf, $random(seed));
        end
        for (int i = 0; i < 2 * NUM_ADDRS; i++) begin
            pick = {$random(seed)} % NUM_ADDRS;
            data_access(1'b1, bus_addr_t'(addrs[pick]), byte_en_t'($random(seed)),
                        $random(seed));
        end
        for (int i = 0; i < NUM_ADDRS; i++) begin
            data_access(1'b0, bus_addr_t'(addrs[i]), 4'hf, '0);
        end
        bus_idle();
        wait_drain("RAM read");

        test_id = 2;
        for (int i = 0; i < NUM_ADDRS; i++) begin
            instr_fetch(addrs[i]);
        end
        bus_idle();
        wait_drain("instruction fetch");

        test_id = 3;
        data_access(1'b0, `MEM_STATUS_ADDR, 4'hf, '0);
        data_access(1'b0, `MEM_TIMER_CNT_ADDR, 4'hf, '0);
        data_access(1'b0, 32'h0001_0000, 4'hf, '0);
        data_access(1'b0, 32'hdead_beec, 4'hf, '0);
        bus_idle();
        wait_drain("zero read");

        test_id = 4;
        data_access(1'b1, `MEM_STATUS_ADDR, 4'hf, `MEM_PASS_MAGIC);
        bus_idle();
        wait_level(SEL_PASSED, 1'b1, 5, "tests_passed pulse");
        data_access(1'b1, `MEM_STATUS_ADDR, 4'hf, `MEM_FAIL_VALUE);
        bus_idle();
        wait_level(SEL_FAILED, 1'b1, 5, "tests_failed pulse");
        data_access(1'b1, `MEM_EXIT_ADDR, 4'hf, 32'h0000_002a);
        bus_idle();
        wait_level(SEL_EXIT, 1'b1, 5, "exit_valid pulse");
        data_access(1'b1, `MEM_EXIT_ZERO_ADDR, 4'hf, 32'h5555_aaaa);
        bus_idle();
        wait_level(SEL_EXIT, 1'b1, 5, "exit_valid pulse after exit-zero write");
        wait_drain("status write");

        // The checker verifies the exact cycle in which the interrupt rises.
        test_id = 5;
        data_access(1'b1, `MEM_TIMER_MASK_ADDR, 4'hf, 32'h1 << `MEM_TIMER_IRQ_ID);
        data_access(1'b1, `MEM_TIMER_CNT_ADDR, 4'hf, TIMER_COUNT);
        bus_idle();
        wait_level(SEL_IRQ, 1'b1, TIMER_COUNT + 5, "timer interrupt");
        @(negedge clk);
        irq_ack = 1'b1;
        irq_id  = irq_id_t'(`MEM_TIMER_IRQ_ID);
        bus_idle();
        wait_level(SEL_IRQ, 1'b0, 5, "timer interrupt to clear");
        data_access(1'b1, `MEM_TIMER_MASK_ADDR, 4'hf, '0);
        data_access(1'b1, `MEM_TIMER_CNT_ADDR, 4'hf, 32'd3);
        bus_idle();
        repeat (8) @(negedge clk);
        wait_drain("timer write");

        $display("Summary: %0d check errors, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
mem_pkg.sv
addr_decoder.sv
dual_port_ram.sv
periph_regs.sv
response_stage.sv
mem_model_top.sv
mem_checker.sv
tb_mem_model.sv
